//--- src/axi_ls_macros.svh
`ifndef AXI_LS_MACROS_SVH
`define AXI_LS_MACROS_SVH

// bus widths
`define AXI_LS_XLEN         64
`define AXI_LS_ADDR_W       64
`define AXI_LS_ID_W         4
`define AXI_LS_USER_W       1

// on-chip RAM window
`define AXI_LS_RAM_BASE     64'h0000_0000_8000_0000
`define AXI_LS_RAM_WORDS    256             // 64-bit words

// fixed transaction attributes
`define AXI_LS_ID           4'd1
`define AXI_LS_PROT         3'b000          // unprivileged, secure, data
`define AXI_LS_AWCACHE      4'b1111         // write-back, read and write allocate
`define AXI_LS_ARCACHE      4'b0010         // normal, non-cacheable, non-bufferable
`define AXI_LS_BURST_INCR   2'b01
`define AXI_LS_LEN_SINGLE   8'd0            // one beat per burst
`define AXI_LS_SIZE_FULL    3'd3            // log2 of bytes per beat

// byte lanes per beat
`define AXI_LS_STRB_W       (`AXI_LS_XLEN / 8)

`endif

//--- src/axi_pkg.sv
package axi_pkg;

    `include "axi_ls_macros.svh"

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // shared by aw and ar
    typedef struct packed {
        logic [`AXI_LS_ADDR_W-1:0] addr;
        logic [2:0]                prot;
        logic [`AXI_LS_ID_W-1:0]   id;
        logic [`AXI_LS_USER_W-1:0] user;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
        logic                      lock;
        logic [3:0]                cache;
        logic [3:0]                qos;
        logic [3:0]                region;
    } axi_ax_t;

    typedef struct packed {
        logic [`AXI_LS_XLEN-1:0]   data;
        logic [`AXI_LS_STRB_W-1:0] strb;
        logic                      last;
        logic [`AXI_LS_USER_W-1:0] user;
    } axi_w_t;

    typedef struct packed {
        resp_t                     resp;
        logic [`AXI_LS_ID_W-1:0]   id;
        logic [`AXI_LS_USER_W-1:0] user;
    } axi_b_t;

    typedef struct packed {
        logic [`AXI_LS_XLEN-1:0]   data;
        resp_t                     resp;
        logic                      last;
        logic [`AXI_LS_ID_W-1:0]   id;
        logic [`AXI_LS_USER_W-1:0] user;
    } axi_r_t;

endpackage

//--- src/lsu_pkg.sv
package lsu_pkg;

    `include "axi_ls_macros.svh"

    typedef logic [`AXI_LS_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_LS_XLEN-1:0]   data_t;
    typedef logic [`AXI_LS_STRB_W-1:0] strb_t;

    // write channel, gray-ordered like the read side
    typedef enum logic [1:0] {
        w_idle    = 2'b00,
        w_aw_wait = 2'b01,
        w_w_wait  = 2'b11,
        w_b_wait  = 2'b10     // also holds the completion level
    } w_state_e;

    typedef enum logic [1:0] {
        r_idle    = 2'b00,
        r_ar_wait = 2'b01,
        r_r_wait  = 2'b11,
        r_done    = 2'b10
    } r_state_e;

endpackage

//--- src/axi_ls_ctrl.sv
module axi_ls_ctrl
    import lsu_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic wr_valid_i,
    input  logic rw_valid_i,
    input  logic addr_same_i,
    input  logic aw_ready_i,
    input  logic w_ready_i,
    input  logic b_valid_i,
    input  logic ar_ready_i,
    input  logic r_valid_i,
    output logic aw_valid_o,
    output logic w_valid_o,
    output logic b_ready_o,
    output logic ar_valid_o,
    output logic r_ready_o,
    output logic addr_load_o,
    output logic rdata_capture_o,
    output logic rdata_release_o,
    output logic wr_ok_o,
    output logic rd_done_o
);

    w_state_e w_state;
    w_state_e w_next;
    r_state_e r_state;
    r_state_e r_next;
    logic     wr_done;      // b seen for the current address
    logic     b_fire;
    logic     r_fire;

    assign b_fire = b_valid_i & b_ready_o;
    assign r_fire = r_valid_i & r_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state <= w_idle;
            r_state <= r_idle;
        end else begin
            w_state <= w_next;
            r_state <= r_next;
        end
    end

    // write channel
    always_comb begin
        w_next = w_state;
        case (w_state)
            w_idle:    if (wr_valid_i) w_next = w_aw_wait;
            w_aw_wait: if (aw_ready_i) w_next = w_w_wait;
            w_w_wait:  if (w_ready_i)  w_next = w_b_wait;
            w_b_wait: begin
                // response must land before we follow the request again
                if (wr_done && !wr_valid_i) begin
                    w_next = w_idle;
                end else if (wr_done && !addr_same_i) begin
                    w_next = w_aw_wait;
                end
            end
            default:   w_next = w_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_done <= 1'b0;
        end else if (w_next != w_b_wait) begin
            wr_done <= 1'b0;
        end else if (b_fire) begin
            wr_done <= 1'b1;
        end
    end

    // read channel
    always_comb begin
        r_next = r_state;
        case (r_state)
            r_idle:    if (rw_valid_i) r_next = r_ar_wait;
            r_ar_wait: if (ar_ready_i) r_next = r_r_wait;
            r_r_wait:  if (r_valid_i)  r_next = r_done;
            r_done: begin
                if (!rw_valid_i) begin
                    r_next = r_idle;
                end else if (!addr_same_i) begin
                    r_next = r_ar_wait;    // new address while held
                end
            end
            default:   r_next = r_idle;
        endcase
    end

    assign aw_valid_o = (w_state == w_aw_wait);
    assign w_valid_o  = (w_state == w_w_wait);
    assign b_ready_o  = (w_state == w_b_wait) && !wr_done;
    assign ar_valid_o = (r_state == r_ar_wait);
    assign r_ready_o  = (r_state == r_r_wait);

    assign addr_load_o     = aw_valid_o | ar_valid_o;
    assign rdata_capture_o = r_fire;
    assign rdata_release_o = (r_state == r_done) && (r_next != r_done);

    // completion levels fall at once on an address change
    assign wr_ok_o   = (w_state == w_b_wait) && wr_done && addr_same_i;
    assign rd_done_o = (r_state == r_done) && addr_same_i;

    assert property (@(posedge clock) disable iff (!reset) !(wr_valid_i && rw_valid_i))
        else $error("read and write requests active together");

    // the address register reloads every wait cycle, so addr_same_i shows a held address
    assert property (@(posedge clock) disable iff (!reset)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && addr_same_i)
        else $error("aw_valid or its address dropped before aw_ready");

    assert property (@(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && addr_same_i)
        else $error("ar_valid or its address dropped before ar_ready");

endmodule

//--- src/axi_ls_addr_track.sv
module axi_ls_addr_track
    import lsu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  addr_t addr_i,
    input  logic  load_i,
    output logic  addr_same_o
);

    addr_t addr_q;      // address of the transaction in flight

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            addr_q <= '0;
        end else if (load_i) begin
            addr_q <= addr_i;
        end
    end

    // live compare, no register stage
    assign addr_same_o = (addr_i == addr_q);

    // the payload is built from the live address, so it must hold
    // for the whole address phase
    assert property (@(posedge clock) disable iff (!reset)
        load_i ##1 load_i |-> $stable(addr_i))
        else $error("request address changed during the address phase");

endmodule

//--- src/axi_ls_rdata.sv
module axi_ls_rdata
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  axi_r_t r_i,
    input  logic   capture_i,
    input  logic   release_i,
    input  logic   done_i,
    output data_t  data_o,
    output logic   ready_o
);

    data_t data_q;
    logic  valid_q;

    always_ff @(posedge clock) begin
        if (capture_i) begin
            data_q <= r_i.data;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (capture_i) begin
            valid_q <= 1'b1;
        end else if (release_i) begin
            valid_q <= 1'b0;
        end
    end

    // zero unless the read is complete for the held address
    assign ready_o = done_i & valid_q;
    assign data_o  = ready_o ? data_q : '0;

endmodule

//--- src/axi_ram_slave.sv
`include "axi_ls_macros.svh"

module axi_ram_slave
    import axi_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    aw_valid_i,
    input  axi_ax_t aw_i,
    input  logic    w_valid_i,
    input  axi_w_t  w_i,
    input  logic    b_ready_i,
    input  logic    ar_valid_i,
    input  axi_ax_t ar_i,
    input  logic    r_ready_i,
    output logic    aw_ready_o,
    output logic    w_ready_o,
    output logic    b_valid_o,
    output axi_b_t  b_o,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output axi_r_t  r_o
);

    localparam int IDX_W = $clog2(`AXI_LS_RAM_WORDS);
    localparam int OFF_W = $clog2(`AXI_LS_STRB_W);
    localparam logic [`AXI_LS_ADDR_W-1:0] RAM_LIMIT =
        `AXI_LS_RAM_BASE + `AXI_LS_RAM_WORDS * `AXI_LS_STRB_W;

    typedef enum logic [1:0] {ws_idle, ws_data, ws_resp} ws_state_e;
    typedef enum logic {rs_idle, rs_resp} rs_state_e;

    logic [`AXI_LS_XLEN-1:0] mem [`AXI_LS_RAM_WORDS];
    ws_state_e               ws_state;
    rs_state_e               rs_state;
    logic [IDX_W-1:0]        wr_idx_q;
    logic                    wr_hit_q;     // aw address fell in the window
    axi_b_t                  b_q;
    axi_r_t                  r_q;

    function automatic logic in_window(input logic [`AXI_LS_ADDR_W-1:0] addr);
        return (addr >= `AXI_LS_RAM_BASE) && (addr < RAM_LIMIT);
    endfunction

    assign aw_ready_o = (ws_state == ws_idle);
    assign w_ready_o  = (ws_state == ws_data);
    assign b_valid_o  = (ws_state == ws_resp);
    assign ar_ready_o = (rs_state == rs_idle);
    assign r_valid_o  = (rs_state == rs_resp);
    assign b_o        = b_q;
    assign r_o        = r_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ws_state <= ws_idle;
            rs_state <= rs_idle;
        end else begin
            case (ws_state)
                ws_idle: if (aw_valid_i) ws_state <= ws_data;
                ws_data: if (w_valid_i)  ws_state <= ws_resp;
                default: if (b_ready_i)  ws_state <= ws_idle;   // b held until taken
            endcase
            if (ar_ready_o && ar_valid_i) begin
                rs_state <= rs_resp;
            end else if (r_valid_o && r_ready_i) begin
                rs_state <= rs_idle;
            end
        end
    end

    // write sequencer payload and memory update
    always_ff @(posedge clock) begin
        if (aw_valid_i && aw_ready_o) begin
            wr_idx_q <= aw_i.addr[OFF_W +: IDX_W];
            wr_hit_q <= in_window(aw_i.addr);
            b_q.id   <= aw_i.id;
            b_q.user <= aw_i.user;
        end
        if (w_valid_i && w_ready_o) begin
            b_q.resp <= wr_hit_q ? RESP_OKAY : RESP_SLVERR;
            for (int i = 0; i < `AXI_LS_STRB_W; i++) begin
                if (wr_hit_q && w_i.strb[i]) begin
                    mem[wr_idx_q][8*i +: 8] <= w_i.data[8*i +: 8];
                end
            end
        end
    end

    // read sequencer payload, zero data outside the window
    always_ff @(posedge clock) begin
        if (ar_valid_i && ar_ready_o) begin
            r_q.data <= in_window(ar_i.addr) ? mem[ar_i.addr[OFF_W +: IDX_W]] : '0;
            r_q.resp <= in_window(ar_i.addr) ? RESP_OKAY : RESP_SLVERR;
            r_q.last <= 1'b1;
            r_q.id   <= ar_i.id;
            r_q.user <= ar_i.user;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        w_valid_i && w_ready_o |-> w_i.last)
        else $error("w beat without last on a single-beat write");

endmodule

//--- src/axi_ls_top.sv
`include "axi_ls_macros.svh"

module axi_ls_top
    import axi_pkg::*;
    import lsu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  wr_valid_i,
    input  logic  rw_valid_i,
    input  data_t rw_w_data_i,
    input  strb_t rw_w_mask_i,
    input  addr_t rw_addr_i,
    output logic  wr_ok_o,
    output logic  rw_ready_o,
    output data_t data_read_o
);

    logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic    ar_valid, ar_ready, r_valid, r_ready;
    logic    addr_same, addr_load, rdata_capture, rdata_release, rd_done;
    axi_ax_t aw_pl;
    axi_ax_t ar_pl;
    axi_w_t  w_pl;
    axi_b_t  b_pl;
    axi_r_t  r_pl;

    // single beat payloads straight from the core request
    always_comb begin
        aw_pl        = '0;          // lock, qos, region, user stay zero
        aw_pl.addr   = rw_addr_i;
        aw_pl.prot   = `AXI_LS_PROT;
        aw_pl.id     = `AXI_LS_ID;
        aw_pl.len    = `AXI_LS_LEN_SINGLE;
        aw_pl.size   = `AXI_LS_SIZE_FULL;
        aw_pl.burst  = `AXI_LS_BURST_INCR;
        aw_pl.cache  = `AXI_LS_AWCACHE;
        ar_pl        = aw_pl;
        ar_pl.cache  = `AXI_LS_ARCACHE;
        w_pl.data    = rw_w_data_i;
        w_pl.strb    = rw_w_mask_i;
        w_pl.last    = w_valid;     // only beat of the burst
        w_pl.user    = '0;
    end

    axi_ls_ctrl axi_ls_ctrl_inst (
        .clock, .reset, .wr_valid_i, .rw_valid_i,
        .addr_same_i(addr_same), .aw_ready_i(aw_ready), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .ar_ready_i(ar_ready), .r_valid_i(r_valid),
        .aw_valid_o(aw_valid), .w_valid_o(w_valid), .b_ready_o(b_ready),
        .ar_valid_o(ar_valid), .r_ready_o(r_ready), .addr_load_o(addr_load),
        .rdata_capture_o(rdata_capture), .rdata_release_o(rdata_release),
        .wr_ok_o, .rd_done_o(rd_done)
    );

    axi_ls_addr_track axi_ls_addr_track_inst (
        .clock, .reset, .addr_i(rw_addr_i), .load_i(addr_load), .addr_same_o(addr_same)
    );

    axi_ls_rdata axi_ls_rdata_inst (
        .clock, .reset, .r_i(r_pl), .capture_i(rdata_capture), .release_i(rdata_release),
        .done_i(rd_done), .data_o(data_read_o), .ready_o(rw_ready_o)
    );

    axi_ram_slave axi_ram_slave_inst (
        .clock, .reset,
        .aw_valid_i(aw_valid), .aw_i(aw_pl), .w_valid_i(w_valid), .w_i(w_pl),
        .b_ready_i(b_ready), .ar_valid_i(ar_valid), .ar_i(ar_pl), .r_ready_i(r_ready),
        .aw_ready_o(aw_ready), .w_ready_o(w_ready), .b_valid_o(b_valid), .b_o(b_pl),
        .ar_ready_o(ar_ready), .r_valid_o(r_valid), .r_o(r_pl)
    );

endmodule

//--- bench/axi_ls_tb_tests.svh
task automatic reset_and_full_write();
    addr_t a;
    data_t d;
    data_t got;
    a = `AXI_LS_RAM_BASE + 3 * 8;
    d = lfsr_bits(64);
    check_flag(wr_ok, 1'b0, "wr_ok_o after reset");
    check_flag(rw_ready, 1'b0, "rw_ready_o after reset");
    check_data(data_read, '0, "data_read_o after reset");
    write_word(a, d, 8'hff);
    read_word(a, got);
    check_data(got, d, "full-mask read-back");
endtask

task automatic partial_mask_merge();
    addr_t a;
    data_t d;
    data_t exp;
    data_t got;
    a   = `AXI_LS_RAM_BASE + 3 * 8;
    d   = lfsr_bits(64);
    exp = merge_bytes(model[3], d, 8'h5a);     // old word with lanes 1,3,4,6 replaced
    write_word(a, d, 8'h5a);
    read_word(a, got);
    check_data(got, exp, "partial-mask read-back");
endtask

task automatic held_read_address_change();
    write_word(`AXI_LS_RAM_BASE + 9 * 8, lfsr_bits(64), 8'hff);
    rw_addr  = `AXI_LS_RAM_BASE + 3 * 8;
    rw_valid = 1'b1;
    wait_read_ready("held read of word 3");
    check_data(data_read, model[3], "first data with the address held");
    repeat (4) begin
        @(negedge clock);
        check_flag(rw_ready, 1'b1, "rw_ready_o with the address held");
        check_data(data_read, model[3], "data_read_o with the address held");
    end
    rw_addr = `AXI_LS_RAM_BASE + 9 * 8;      // request stays high
    #(CLK_PERIOD / 4);
    check_flag(rw_ready, 1'b0, "rw_ready_o right after the address change");
    check_data(data_read, '0, "data_read_o right after the address change");
    wait_read_ready("held read of word 9");
    check_data(data_read, model[9], "data_read_o after the address change");
    rw_valid = 1'b0;
    @(negedge clock);
endtask

task automatic outside_window_access();
    addr_t outside;
    data_t got;
    outside = 64'h0000_0000_0000_1018;       // index bits alias word 3
    write_word(outside, ~model[3], 8'hff);
    read_word(`AXI_LS_RAM_BASE + 3 * 8, got);
    check_data(got, model[3], "word 3 after a write outside the window");
    read_word(outside, got);
    check_data(got, '0, "read outside the window");
endtask

task automatic random_write_readback();
    logic  touched [16];
    int    idx;
    strb_t mask;
    data_t got;
    foreach (touched[i]) begin
        touched[i] = 1'b0;
    end
    for (int n = 0; n < 40; n++) begin
        idx  = int'(lfsr_bits(4));
        // first touch writes the whole word so no byte stays unknown
        mask = touched[idx] ? strb_t'(lfsr_bits(8)) : 8'hff;
        touched[idx] = 1'b1;
        write_word(`AXI_LS_RAM_BASE + (RAND_BASE + idx) * 8, lfsr_bits(64), mask);
    end
    for (int i = 0; i < 16; i++) begin
        if (touched[i]) begin
            read_word(`AXI_LS_RAM_BASE + (RAND_BASE + i) * 8, got);
            check_data(got, model[RAND_BASE + i], $sformatf("random word %0d", RAND_BASE + i));
        end
    end
endtask

//--- bench/axi_ls_tb.sv
`include "axi_ls_macros.svh"

module axi_ls_tb
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int WAIT_BOUND  = 16;          // cycles for one transaction
    localparam int TXN_COUNT   = 70;          // transactions over all tests
    localparam int CYCLE_LIMIT = TXN_COUNT * (WAIT_BOUND + 2) + 64;
    localparam int RAND_BASE   = 32;          // first word of the random region

    logic  clock;
    logic  reset;
    logic  wr_valid;
    logic  rw_valid;
    data_t rw_w_data;
    strb_t rw_w_mask;
    addr_t rw_addr;
    logic  wr_ok;
    logic  rw_ready;
    data_t data_read;

    data_t       model [`AXI_LS_RAM_WORDS];   // scoreboard copy of the RAM
    logic [31:0] lfsr_q = 32'h0cca_b428;
    int          error_count = 0;
    int          timeout_count = 0;
    int          cycle_count = 0;

    axi_ls_top axi_ls_top_inst (
        .clock, .reset, .wr_valid_i(wr_valid), .rw_valid_i(rw_valid),
        .rw_w_data_i(rw_w_data), .rw_w_mask_i(rw_w_mask), .rw_addr_i(rw_addr),
        .wr_ok_o(wr_ok), .rw_ready_o(rw_ready), .data_read_o(data_read)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function logic [63:0] lfsr_bits(input int n);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value  = {value[62:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
        end
        return value;
    endfunction

    function automatic logic addr_in_ram(input addr_t a);
        return (a >= `AXI_LS_RAM_BASE) && (a < `AXI_LS_RAM_BASE + `AXI_LS_RAM_WORDS * 8);
    endfunction

    function automatic int word_index(input addr_t a);
        return int'((a - `AXI_LS_RAM_BASE) >> 3);
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t mask);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_read_ready(input string what);
        int waited;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!rw_ready && waited < WAIT_BOUND);
        if (!rw_ready) begin
            $display("timeout: rw_ready_o never rose for the %s", what);
            timeout_count++;
        end
    endtask

    // called on a falling edge, returns on a falling edge with the bus idle
    task automatic write_word(input addr_t a, input data_t d, input strb_t mask);
        int waited;
        rw_addr   = a;
        rw_w_data = d;
        rw_w_mask = mask;
        wr_valid  = 1'b1;
        waited    = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!wr_ok && waited < WAIT_BOUND);
        if (!wr_ok) begin
            $display("timeout: wr_ok_o never rose for the write to %h", a);
            timeout_count++;
        end else if (addr_in_ram(a)) begin
            model[word_index(a)] = merge_bytes(model[word_index(a)], d, mask);
        end
        wr_valid = 1'b0;
        @(negedge clock);   // idle cycle so a repeated address starts fresh
    endtask

    task automatic read_word(input addr_t a, output data_t got);
        rw_addr  = a;
        rw_valid = 1'b1;
        wait_read_ready("read");
        got      = data_read;
        rw_valid = 1'b0;
        @(negedge clock);
        check_data(data_read, '0, "data_read_o after the read ends");
    endtask

    `include "axi_ls_tb_tests.svh"

    initial begin
        reset     = 1'b0;
        wr_valid  = 1'b0;
        rw_valid  = 1'b0;
        rw_w_data = '0;
        rw_w_mask = '0;
        rw_addr   = '0;
        repeat (4) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        reset_and_full_write();
        partial_mask_merge();
        held_read_address_change();
        outside_window_access();
        random_write_readback();
        $display("summary: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("summary: %0d errors, %0d timeouts", error_count, timeout_count + 1);
        $display("tests failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
+incdir+bench
src/axi_pkg.sv
src/lsu_pkg.sv
src/axi_ls_ctrl.sv
src/axi_ls_addr_track.sv
src/axi_ls_rdata.sv
src/axi_ram_slave.sv
src/axi_ls_top.sv
bench/axi_ls_tb.sv

//--- Bender.yml
package:
  name: axi_ls

sources:
  - include_dirs:
      - src
    files:
      - src/axi_pkg.sv
      - src/lsu_pkg.sv
      - src/axi_ls_ctrl.sv
      - src/axi_ls_addr_track.sv
      - src/axi_ls_rdata.sv
      - src/axi_ram_slave.sv
      - src/axi_ls_top.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/axi_ls_tb.sv
